//--- Bender.yml
package:
  name: cpuProject

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpuPkg.sv
      - verilog/wordRam.sv
      - verilog/regFile.sv
      - verilog/fetchUnit.sv
      - verilog/instDecode.sv
      - verilog/aluExecute.sv
      - verilog/resultStage.sv
      - verilog/cpuTop.sv
  - target: test
    files:
      - bench/cpuTop_tb.sv

//--- bench/cpuTop_tb.sv
`timescale 1ns/1ps

module cpuTop_tb;
	import cpuPkg::*;

	localparam int MAX_ENTRIES = 384;

	logic clk;
	logic rst;
	logic run;
	logic load;
	pcT loadAddr;
	instrWordT loadData;
	pcT pc;
	logic halted;
	logic wbValid;
	regAddrT wbReg;
	dataWordT wbData;

	// three words per line: kind, argument, value
	logic [31:0] entries [MAX_ENTRIES];
	logic [31:0] expQueue [$];
	logic [31:0] nextEntry;
	int errors;
	int checks;
	int cycles;
	int cycleLimit;

	cpuTop i_dut (
		.clk(clk), .rst(rst), .run(run), .load(load),
		.loadAddr(loadAddr), .loadData(loadData),
		.pc(pc), .halted(halted),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	always #20 clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// writeback trace, one entry per wbValid cycle
	always @(negedge clk) begin
		if (wbValid) begin
			if (expQueue.size() == 0) begin
				errors++;
				$display("unexpected writeback to register %0d at %0t", wbReg, $time);
			end else begin
				nextEntry = expQueue.pop_front();
				checkValue("wbReg", wbReg, nextEntry[31:16]);
				checkValue("wbData", wbData, nextEntry[15:0]);
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: the run went past %0d cycles", cycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// main flow
	initial begin : mainFlow
		int idx;
		int kind;
		int loadCount;
		int expectCount;
		clk = 1'b0;
		rst = 1'b0;
		run = 1'b0;
		load = 1'b0;
		loadAddr = '0;
		loadData = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		cycleLimit = 0;
		loadCount = 0;
		expectCount = 0;
		for (idx = 0; idx < MAX_ENTRIES; idx++)
			entries[idx] = '0;
		$readmemh("bench/program_input.txt", entries);
		for (idx = 0; idx < MAX_ENTRIES; idx += 3) begin
			if (entries[idx] == 1)
				loadCount++;
			if (entries[idx] == 3)
				expectCount++;
		end
		cycleLimit = 64 * (loadCount + expectCount) + 200;
		if (loadCount == 0) begin
			errors++;
			$display("the program file holds no load lines");
		end

		repeat (4) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		checkValue("pc", pc, 0);
		checkValue("halted", halted, 0);
		checkValue("wbValid", wbValid, 0);

		idx = 0;
		while (idx < MAX_ENTRIES && entries[idx] != 0) begin
			kind = entries[idx];
			case (kind)
				1: begin
					@(posedge clk);
					load <= 1'b1;
					loadAddr <= entries[idx+1][6:0];
					loadData <= entries[idx+2];
				end
				2: begin
					@(posedge clk);
					load <= 1'b0;
					run <= 1'b1;
				end
				3: expQueue.push_back({entries[idx+1][15:0], entries[idx+2][15:0]});
				4: begin
					do begin
						@(negedge clk);
					end while (halted !== 1'b1);
					checkValue("pc", pc, entries[idx+1]);
					// core must stay frozen
					repeat (8) begin
						@(negedge clk);
						checkValue("halted", halted, 1);
						checkValue("pc", pc, entries[idx+1]);
					end
					if (expQueue.size() != 0) begin
						errors++;
						$display("%0d expected writebacks never appeared", expQueue.size());
						expQueue.delete();
					end
					@(posedge clk);
					run <= 1'b0;
					// run low is seen on the next edge
					repeat (2) @(negedge clk);
					checkValue("halted", halted, 0);
					checkValue("pc", pc, 0);
				end
				default: begin
					errors++;
					$display("unknown line kind %0d in the program file", kind);
				end
			endcase
			idx += 3;
		end

		@(negedge clk);
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- bench/program_input.txt
// kind arg value: 1 = load (address, word), 2 = run, 3 = expected writeback (reg, value)
// 4 = halt (expected halt pc); all fields hex
1 00 C0400005
1 01 C080FFFD
1 02 10C3000A
1 03 10C20000
1 04 21070004
1 05 21020000
1 06 314900FF
1 07 31460000
1 08 41830F00
1 09 418A0000
1 0A 51CDFFFF
1 0B 51C20000
1 0C 62050001
1 0D 62020000
1 0E 72430004
1 0F 71020000
1 10 B0C10020
1 11 A2810020
1 12 F0000000
1 13 C2C00001
2 00 00000000
3 01 00000005
3 02 0000FFFD
3 03 0000000F
3 03 00000014
3 04 00000010
3 04 0000FFF5
3 05 000000F5
3 05 00000014
3 06 00000F05
3 06 00000F15
3 07 0000F0EA
3 07 0000F0EF
3 08 00000001
3 08 00000000
3 09 00000050
3 04 000000A0
3 0A 00000014
4 12 00000000
// countdown loop, jump over li r2, write to r0
1 00 C0400003
1 01 20430001
1 02 90020001
1 03 80000005
1 04 C0800BAD
1 05 C0001234
1 06 C0C00042
1 07 10C00000
1 08 F0000000
2 00 00000000
3 01 00000003
3 01 00000002
3 01 00000001
3 01 00000000
3 03 00000042
3 03 00000042
4 08 00000000

//--- cpuProject.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/wordRam.sv
verilog/regFile.sv
verilog/fetchUnit.sv
verilog/instDecode.sv
verilog/aluExecute.sv
verilog/resultStage.sv
verilog/cpuTop.sv
bench/cpuTop_tb.sv

//--- verilog/aluExecute.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module aluExecute (
	input  cpuPkg::aluFuncT  aluFunc,
	input  logic             useImm,
	input  cpuPkg::dataWordT imm,
	input  cpuPkg::dataWordT rsData,
	input  cpuPkg::dataWordT rdData,
	input  logic             isJump,
	input  logic             isBnz,
	output cpuPkg::dataWordT aluResult,
	output logic             pcLoad,
	output cpuPkg::pcT       pcTarget
);
	import cpuPkg::*;

	dataWordT opB;
	logic lessThan;

	// register forms take rd as second source
	assign opB = useImm ? imm : rdData;

	assign lessThan = $signed(rsData) < $signed(opB);

	////////////////////////////////////////////////////////////
	// alu
	always_comb begin
		case (aluFunc)
			ALU_PASS: aluResult = opB;
			ALU_ADD: aluResult = rsData + opB;
			ALU_SUB: aluResult = rsData - opB;
			ALU_AND: aluResult = rsData & opB;
			ALU_OR: aluResult = rsData | opB;
			ALU_XOR: aluResult = rsData ^ opB;
			ALU_SLT: aluResult = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
			ALU_SHL: aluResult = rsData << opB[3:0];
			default: aluResult = opB;
		endcase
	end

	////////////////////////////////////////////////////////////
	// next pc
	assign pcLoad = isJump | (isBnz & (rsData != '0));
	assign pcTarget = imm[`PC_WIDTH-1:0];

endmodule

//--- verilog/cpuPkg.sv
`include "cpu_settings.svh"

package cpuPkg;

	typedef logic [`DATA_WIDTH-1:0] dataWordT;
	typedef logic [`INSTR_WIDTH-1:0] instrWordT;
	typedef logic [`PC_WIDTH-1:0] pcT;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

	// codes 13 and 14 are unused and decode as halt
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR = 4'd4,
		OP_XOR = 4'd5,
		OP_SLT = 4'd6,
		OP_SHL = 4'd7,
		OP_JMP = 4'd8,
		OP_BNZ = 4'd9,
		OP_LOAD = 4'd10,
		OP_STORE = 4'd11,
		OP_LI = 4'd12,
		OP_HALT = 4'd15
	} opcodeT;

	// same order as opcodes 0 to 7
	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SHL
	} aluFuncT;

endpackage

//--- verilog/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	input  logic              load,
	input  cpuPkg::pcT        loadAddr,
	input  cpuPkg::instrWordT loadData,
	output cpuPkg::pcT        pc,
	output logic              halted,
	output logic              wbValid,
	output cpuPkg::regAddrT   wbReg,
	output cpuPkg::dataWordT  wbData
);
	import cpuPkg::*;

	instrWordT instr;
	logic phase;
	aluFuncT aluFunc;
	logic useImm;
	dataWordT imm;
	dataWordT rsData;
	dataWordT rdData;
	regAddrT rd;
	logic isJump;
	logic isBnz;
	logic isLoad;
	logic isStore;
	logic regWrite;
	logic haltExec;
	dataWordT aluResult;
	logic pcLoad;
	pcT pcTarget;
	logic wrEn;
	regAddrT wrAddr;
	dataWordT wrData;

	fetchUnit i_fetch (
		.clk(clk), .rst(rst), .run(run), .load(load),
		.loadAddr(loadAddr), .loadData(loadData),
		.pcLoad(pcLoad), .pcTarget(pcTarget), .haltExec(haltExec),
		.instr(instr), .phase(phase), .pc(pc), .halted(halted)
	);

	instDecode i_decode (
		.clk(clk), .instr(instr), .phase(phase), .halted(halted),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.aluFunc(aluFunc), .useImm(useImm), .imm(imm),
		.rsData(rsData), .rdData(rdData), .rd(rd),
		.isJump(isJump), .isBnz(isBnz), .isLoad(isLoad), .isStore(isStore),
		.regWrite(regWrite), .haltExec(haltExec)
	);

	aluExecute i_alu (
		.aluFunc(aluFunc), .useImm(useImm), .imm(imm),
		.rsData(rsData), .rdData(rdData), .isJump(isJump), .isBnz(isBnz),
		.aluResult(aluResult), .pcLoad(pcLoad), .pcTarget(pcTarget)
	);

	resultStage i_result (
		.clk(clk), .rst(rst), .aluResult(aluResult), .rdData(rdData), .rd(rd),
		.isLoad(isLoad), .isStore(isStore), .regWrite(regWrite),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

endmodule

//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define DATA_WIDTH 16
`define INSTR_WIDTH 32
`define PC_WIDTH 7
`define IMEM_DEPTH 128
`define DMEM_ADDR_WIDTH 8
`define DMEM_DEPTH 256
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// instruction field positions
`define OPCODE_MSB 31
`define OPCODE_LSB 28
`define RD_MSB 26
`define RD_LSB 22
`define RS_MSB 21
`define RS_LSB 17
`define IMM_FLAG_BIT 16
`define IMM_MSB 15

`endif

//--- verilog/fetchUnit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetchUnit (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	input  logic              load,
	input  cpuPkg::pcT        loadAddr,
	input  cpuPkg::instrWordT loadData,
	input  logic              pcLoad,
	input  cpuPkg::pcT        pcTarget,
	input  logic              haltExec,
	output cpuPkg::instrWordT instr,
	output logic              phase,
	output cpuPkg::pcT        pc,
	output logic              halted
);
	import cpuPkg::*;

	instrWordT imemWord;

	// program loader only writes while stopped
	wordRam #(.wordT(instrWordT), .depth(`IMEM_DEPTH)) i_imem (
		.clk  (clk),
		.we   (load & ~run),
		.waddr(loadAddr),
		.raddr(pc),
		.wdata(loadData),
		.rdata(imemWord)
	);

	////////////////////////////////////////////////////////////
	// pc, phase and halt
	always_ff @(posedge clk) begin
		if (!rst || !run) begin
			pc <= '0;
			phase <= 1'b0;
			halted <= 1'b0;
		end else if (!halted) begin
			phase <= ~phase;
			if (phase) begin
				// halt keeps pc on the halt word
				if (haltExec)
					halted <= 1'b1;
				else if (pcLoad)
					pc <= pcTarget;
				else
					pc <= pc + 1'b1;
			end
		end
	end

	// instruction register, fetch edge
	always_ff @(posedge clk) begin
		if (run && !halted && !phase) begin
			instr <= imemWord;
		end
	end

endmodule

//--- verilog/instDecode.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instDecode (
	input  logic            clk,
	input  cpuPkg::instrWordT instr,
	input  logic            phase,
	input  logic            halted,
	input  logic            wrEn,
	input  cpuPkg::regAddrT wrAddr,
	input  cpuPkg::dataWordT wrData,
	output cpuPkg::aluFuncT aluFunc,
	output logic            useImm,
	output cpuPkg::dataWordT imm,
	output cpuPkg::dataWordT rsData,
	output cpuPkg::dataWordT rdData,
	output cpuPkg::regAddrT rd,
	output logic            isJump,
	output logic            isBnz,
	output logic            isLoad,
	output logic            isStore,
	output logic            regWrite,
	output logic            haltExec
);
	import cpuPkg::*;

	opcodeT opcode;
	regAddrT rs;
	logic immFlag;
	logic execute;
	logic writesReg;
	logic jumpOp;
	logic bnzOp;
	logic storeOp;
	logic haltOp;

	assign opcode = opcodeT'(instr[`OPCODE_MSB:`OPCODE_LSB]);
	assign rd = instr[`RD_MSB:`RD_LSB];
	assign rs = instr[`RS_MSB:`RS_LSB];
	assign immFlag = instr[`IMM_FLAG_BIT];
	assign imm = instr[`IMM_MSB:0];

	regFile i_regFile (
		.clk   (clk),
		.wrEn  (wrEn),
		.wrAddr(wrAddr),
		.rsAddr(rs),
		.rdAddr(rd),
		.wrData(wrData),
		.rsData(rsData),
		.rdData(rdData)
	);

	////////////////////////////////////////////////////////////
	// control decode
	always_comb begin
		aluFunc = ALU_PASS;
		useImm = 1'b0;
		writesReg = 1'b0;
		jumpOp = 1'b0;
		bnzOp = 1'b0;
		isLoad = 1'b0;
		storeOp = 1'b0;
		haltOp = 1'b0;
		case (opcode)
			OP_NOP: ;
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SHL: begin
				aluFunc = aluFuncT'(opcode[2:0]);
				useImm = immFlag;
				writesReg = 1'b1;
			end
			OP_JMP: jumpOp = 1'b1;
			OP_BNZ: bnzOp = 1'b1;
			// address is rs plus immediate
			OP_LOAD: begin
				aluFunc = ALU_ADD;
				useImm = 1'b1;
				writesReg = 1'b1;
				isLoad = 1'b1;
			end
			OP_STORE: begin
				aluFunc = ALU_ADD;
				useImm = 1'b1;
				storeOp = 1'b1;
			end
			OP_LI: begin
				useImm = 1'b1;
				writesReg = 1'b1;
			end
			default: haltOp = 1'b1;
		endcase
	end

	// side effects only in execute phase
	assign execute = phase & ~halted;
	assign regWrite = execute & writesReg & (rd != '0);
	assign isJump = execute & jumpOp;
	assign isBnz = execute & bnzOp;
	assign isStore = execute & storeOp;
	assign haltExec = execute & haltOp;

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regFile (
	input  logic             clk,
	input  logic             wrEn,
	input  cpuPkg::regAddrT  wrAddr,
	input  cpuPkg::regAddrT  rsAddr,
	input  cpuPkg::regAddrT  rdAddr,
	input  cpuPkg::dataWordT wrData,
	output cpuPkg::dataWordT rsData,
	output cpuPkg::dataWordT rdData
);
	import cpuPkg::*;

	dataWordT regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// register 0 is hardwired zero
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rdData = (rdAddr == '0) ? '0 : regs[rdAddr];

endmodule

//--- verilog/resultStage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module resultStage (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::dataWordT aluResult,
	input  cpuPkg::dataWordT rdData,
	input  cpuPkg::regAddrT  rd,
	input  logic             isLoad,
	input  logic             isStore,
	input  logic             regWrite,
	output logic             wrEn,
	output cpuPkg::regAddrT  wrAddr,
	output cpuPkg::dataWordT wrData,
	output logic             wbValid,
	output cpuPkg::regAddrT  wbReg,
	output cpuPkg::dataWordT wbData
);
	import cpuPkg::*;

	dataWordT memWord;

	// store source is rd, address from the alu
	wordRam #(.wordT(dataWordT), .depth(`DMEM_DEPTH)) i_dmem (
		.clk  (clk),
		.we   (isStore),
		.waddr(aluResult[`DMEM_ADDR_WIDTH-1:0]),
		.raddr(aluResult[`DMEM_ADDR_WIDTH-1:0]),
		.wdata(rdData),
		.rdata(memWord)
	);

	assign wrEn = regWrite;
	assign wrAddr = rd;
	assign wrData = isLoad ? memWord : aluResult;

	always_ff @(posedge clk) begin
		if (!rst)
			wbValid <= 1'b0;
		else
			wbValid <= wrEn;
	end

	always_ff @(posedge clk) begin
		wbReg <= wrAddr;
		wbData <= wrData;
	end

endmodule

//--- verilog/wordRam.sv
`timescale 1ns/1ps

module wordRam #(
	parameter type wordT = logic [7:0],
	parameter int depth = 16
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  logic [$clog2(depth)-1:0] raddr,
	input  wordT                     wdata,
	output wordT                     rdata
);

	wordT mem [depth];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr];

endmodule
